/* build.f */
logic/lsu_pkg.sv
logic/wb_if.sv
logic/lsu_lane_plan.sv
logic/lsu_load_align.sv
logic/lsu_sequencer.sv
logic/word_ram.sv
logic/unaligned_mem_top.sv
tb/tb_unaligned_mem.sv

/* Makefile */
# Verilator build and run for the unaligned load/store adapter
# pass or fail is read from the simulation log

VERILATOR  ?= verilator
TOP        ?= tb_unaligned_mem
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= Simulation PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_TEXT)" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_unaligned_mem.sv */
// table-driven testbench for the load/store adapter
// a 256-byte reference array mirrors the RAM, so MEM_WORDS is fixed at 64
// table entries are built up front; load expectations come from the reference
// inputs change on the falling edge, results are sampled there too
`timescale 1ns/1ps
`default_nettype none

module tb_unaligned_mem;

   localparam int ADDR_W      = 16;
   localparam int MEM_WORDS   = 64;
   localparam int WAIT_STATES = 2;
   localparam int CLK_PERIOD  = 40;

   localparam logic [1:0] OP_RD   = 2'd0;
   localparam logic [1:0] OP_WR   = 2'd1;
   localparam logic [1:0] OP_BOTH = 2'd2;    // both enables, read wins
   localparam logic [1:0] OP_HOLD = 2'd3;    // store with enable held through busy

   localparam logic [2:0] F3_B  = 3'd0;
   localparam logic [2:0] F3_H  = 3'd1;
   localparam logic [2:0] F3_W  = 3'd2;
   localparam logic [2:0] F3_BU = 3'd4;
   localparam logic [2:0] F3_HU = 3'd5;

   typedef struct packed {
      logic [1:0]  op;
      logic [15:0] addr;
      logic [2:0]  f3;
      logic [31:0] data;
      logic [31:0] exp;
   } entry_t;

   logic              clk;
   logic              rst_x;
   logic              i_rd_en;
   logic              i_wr_en;
   logic [ADDR_W-1:0] i_addr;
   logic [31:0]       i_data;
   logic [2:0]        i_ctrl;
   logic [31:0]       o_data;
   logic              o_busy;

   logic [7:0] ref_mem [256];     // byte image of the RAM
   entry_t     table_q [$];
   integer     seed;
   int         errors;
   int         checks;
   logic       table_ready;

   unaligned_mem_top #(
      .ADDR_W     (ADDR_W),
      .MEM_WORDS  (MEM_WORDS),
      .WAIT_STATES(WAIT_STATES)
   ) u_dut (
      .clk    (clk),
      .rst_x  (rst_x),
      .i_rd_en(i_rd_en),
      .i_wr_en(i_wr_en),
      .i_addr (i_addr),
      .i_data (i_data),
      .i_ctrl (i_ctrl),
      .o_data (o_data),
      .o_busy (o_busy)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic int size_in_bytes(input logic [2:0] f3);
      case (f3[1:0])
         2'd0:    return 1;
         2'd1:    return 2;
         default: return 4;
      endcase
   endfunction

   task automatic ref_store(input logic [15:0] addr, input logic [2:0] f3,
                            input logic [31:0] data);
      logic [7:0] idx;
      for (int i = 0; i < size_in_bytes(f3); i++) begin
         idx          = 8'(int'(addr) + i);    // wraps like the RAM
         ref_mem[idx] = data[8*i +: 8];
      end
   endtask

   function automatic logic [31:0] ref_load(input logic [15:0] addr, input logic [2:0] f3);
      logic [31:0] v;
      logic [7:0]  idx;
      int          n;
      n = size_in_bytes(f3);
      v = 32'h0;
      for (int i = 0; i < n; i++) begin
         idx          = 8'(int'(addr) + i);
         v[8*i +: 8] = ref_mem[idx];
      end
      if (n == 1) v = f3[2] ? {24'h0, v[7:0]} : {{24{v[7]}}, v[7:0]};
      else if (n == 2) v = f3[2] ? {16'h0, v[15:0]} : {{16{v[15]}}, v[15:0]};
      return v;
   endfunction

   task automatic add_entry(input logic [1:0] op, input logic [15:0] addr,
                            input logic [2:0] f3, input logic [31:0] data);
      entry_t e;
      e.op   = op;
      e.addr = addr;
      e.f3   = f3;
      e.data = data;
      e.exp  = 32'h0;
      if (op == OP_RD || op == OP_BOTH) e.exp = ref_load(addr, f3);
      else ref_store(addr, f3, data);       // the held store still counts once
      table_q.push_back(e);
   endtask

   task automatic build_table();
      logic [31:0] rnd;
      int          r;
      int          kind;
      // every word written first, so no load sees an unset byte
      for (int w = 0; w < MEM_WORDS; w++) begin
         rnd = $random(seed);
         add_entry(OP_WR, 16'(4 * w), F3_W, rnd ^ {16'(w), 16'(~w)});
      end
      for (int w = 0; w < MEM_WORDS; w++) add_entry(OP_RD, 16'(4 * w), F3_W, 32'h0);
      // byte and half stores at every lane
      for (int off = 0; off < 4; off++) begin
         add_entry(OP_WR, 16'(64 + off), F3_B, $random(seed));
         add_entry(OP_RD, 16'h0040, F3_W, 32'h0);
         add_entry(OP_WR, 16'(80 + off), F3_H, $random(seed));
         add_entry(OP_RD, 16'h0050, F3_W, 32'h0);
         add_entry(OP_RD, 16'h0054, F3_W, 32'h0);
      end
      // crossing a word boundary
      add_entry(OP_WR, 16'h0063, F3_H, 32'h0000_c3a5);
      add_entry(OP_RD, 16'h0063, F3_H, 32'h0);
      add_entry(OP_RD, 16'h0063, F3_HU, 32'h0);
      add_entry(OP_RD, 16'h0060, F3_W, 32'h0);
      add_entry(OP_RD, 16'h0064, F3_W, 32'h0);
      for (int off = 1; off < 4; off++) begin
         add_entry(OP_WR, 16'(112 + off), F3_W, $random(seed));
         add_entry(OP_RD, 16'(112 + off), F3_W, 32'h0);
         add_entry(OP_RD, 16'h0070, F3_W, 32'h0);
         add_entry(OP_RD, 16'h0074, F3_W, 32'h0);
      end
      // last word wraps to word 0
      for (int off = 1; off < 4; off++) begin
         add_entry(OP_WR, 16'(252 + off), F3_W, $random(seed));
         add_entry(OP_RD, 16'(252 + off), F3_W, 32'h0);
         add_entry(OP_RD, 16'h0000, F3_W, 32'h0);
      end
      add_entry(OP_WR, 16'h00ff, F3_H, 32'h0000_9e81);
      add_entry(OP_RD, 16'h00ff, F3_H, 32'h0);
      add_entry(OP_RD, 16'h00fc, F3_W, 32'h0);
      add_entry(OP_RD, 16'h0000, F3_W, 32'h0);
      // sign and zero extension, bytes 8f 7e f1 80
      add_entry(OP_WR, 16'h0088, F3_W, 32'h80f1_7e8f);
      for (int off = 0; off < 4; off++) begin
         add_entry(OP_RD, 16'(136 + off), F3_B, 32'h0);
         add_entry(OP_RD, 16'(136 + off), F3_BU, 32'h0);
         add_entry(OP_RD, 16'(136 + off), F3_H, 32'h0);
         add_entry(OP_RD, 16'(136 + off), F3_HU, 32'h0);
      end
      // read wins over write, held enable gives one access
      add_entry(OP_BOTH, 16'h0090, F3_W, 32'hdead_beef);
      add_entry(OP_RD, 16'h0090, F3_W, 32'h0);
      add_entry(OP_HOLD, 16'h0095, F3_H, 32'h0000_5aa5);
      add_entry(OP_RD, 16'h0094, F3_W, 32'h0);
      for (int i = 0; i < 48; i++) begin
         r    = $random(seed);
         kind = (r >>> 8) & 32'h7fff;
         if (r[0]) add_entry(OP_WR, 16'(r[15:8]), 3'(kind % 3), $random(seed));
         else begin
            case (kind % 5)
               0:       add_entry(OP_RD, 16'(r[15:8]), F3_B, 32'h0);
               1:       add_entry(OP_RD, 16'(r[15:8]), F3_H, 32'h0);
               2:       add_entry(OP_RD, 16'(r[15:8]), F3_W, 32'h0);
               3:       add_entry(OP_RD, 16'(r[15:8]), F3_BU, 32'h0);
               default: add_entry(OP_RD, 16'(r[15:8]), F3_HU, 32'h0);
            endcase
         end
      end
   endtask

   // called on a falling edge with the DUT idle, returns on one
   task automatic run_entry(input entry_t e, input int k);
      i_addr  = e.addr;
      i_ctrl  = e.f3;
      i_data  = e.data;
      i_rd_en = (e.op == OP_RD) || (e.op == OP_BOTH);
      i_wr_en = (e.op != OP_RD);
      @(posedge clk);
      @(negedge clk);
      assert (o_busy === 1'b1) else begin
         errors = errors + 1;
         $display("Mismatch at %0t: entry %0d, o_busy did not rise", $time, k);
      end
      if (e.op == OP_HOLD) begin
         i_data = ~e.data;                  // a second store would leave this
      end else begin
         i_rd_en = 1'b0;
         i_wr_en = 1'b0;
      end
      while (o_busy !== 1'b0) @(negedge clk);
      i_rd_en = 1'b0;
      i_wr_en = 1'b0;
      if (e.op == OP_RD || e.op == OP_BOTH) begin
         checks = checks + 1;
         assert (o_data === e.exp) else begin
            errors = errors + 1;
            $display("Mismatch at %0t: entry %0d addr %h funct3 %0d got %h expected %h",
                     $time, k, e.addr, e.f3, o_data, e.exp);
         end
      end
   endtask

   initial begin : watchdog
      longint limit_cycles;
      wait (table_ready);
      limit_cycles = 2 * (longint'(table_q.size()) * (2 * WAIT_STATES + 5) + 8);
      #(limit_cycles * CLK_PERIOD);
      $display("timeout: the access table did not finish within %0d cycles", limit_cycles);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      seed        = 32'h9cb8;
      errors      = 0;
      checks      = 0;
      table_ready = 1'b0;
      rst_x       = 1'b0;
      i_rd_en     = 1'b0;
      i_wr_en     = 1'b0;
      i_addr      = '0;
      i_data      = '0;
      i_ctrl      = '0;
      build_table();
      table_ready = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_x = 1'b1;
      assert (o_busy === 1'b0) else begin
         errors = errors + 1;
         $display("Mismatch at %0t: o_busy high after reset", $time);
      end
      foreach (table_q[k]) run_entry(table_q[k], k);
      $display("entries %0d, load checks %0d, errors %0d", table_q.size(), checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* logic/unaligned_mem_top.sv */
// RISC-V load/store adapter with a simulated word RAM
// i_ctrl is funct3; byte, half and word accesses at any byte address
// crossing accesses take two bus beats, o_busy covers the whole access
// o_data is valid once o_busy falls after a read
`timescale 1ns/1ps
`default_nettype none

module unaligned_mem_top #(
   parameter int ADDR_W      = 16,
   parameter int MEM_WORDS   = 1024,
   parameter int WAIT_STATES = 2
) (
   input  logic              clk,
   input  logic              rst_x,
   input  logic              i_rd_en,
   input  logic              i_wr_en,
   input  logic [ADDR_W-1:0] i_addr,
   input  logic [31:0]       i_data,
   input  logic [2:0]        i_ctrl,
   output logic [31:0]       o_data,
   output logic              o_busy
);

   import lsu_pkg::*;

   logic [OFFSET_W-1:0] offset;
   access_ctrl_u        ctrl;
   logic [31:0]         wdata_reg;
   logic [3:0]          sel0;
   logic [3:0]          sel1;
   logic [31:0]         wdata0;
   logic [31:0]         wdata1;
   logic                two_beats;
   logic                capture;
   logic                beat;

   wb_if #(.ADDR_W(ADDR_W)) u_wb ();

   lsu_sequencer #(.ADDR_W(ADDR_W)) u_seq (
      .clk        (clk),
      .rst_x      (rst_x),
      .i_rd_en    (i_rd_en),
      .i_wr_en    (i_wr_en),
      .i_addr     (i_addr),
      .i_data     (i_data),
      .i_ctrl     (i_ctrl),
      .o_busy     (o_busy),
      .wb         (u_wb.master),
      .o_offset   (offset),
      .o_ctrl     (ctrl),
      .o_wdata_reg(wdata_reg),
      .i_sel0     (sel0),
      .i_sel1     (sel1),
      .i_wdata0   (wdata0),
      .i_wdata1   (wdata1),
      .i_two_beats(two_beats),
      .o_capture  (capture),
      .o_beat     (beat)
   );

   lsu_lane_plan u_plan (
      .i_offset   (offset),
      .i_ctrl     (ctrl),
      .i_wdata    (wdata_reg),
      .o_sel0     (sel0),
      .o_sel1     (sel1),
      .o_wdata0   (wdata0),
      .o_wdata1   (wdata1),
      .o_two_beats(two_beats)
   );

   lsu_load_align u_align (
      .clk      (clk),
      .rst_x    (rst_x),
      .i_capture(capture),
      .i_beat   (beat),
      .i_dat    (u_wb.dat_r),
      .i_offset (offset),
      .i_ctrl   (ctrl),
      .o_data   (o_data)
   );

   word_ram #(
      .ADDR_W     (ADDR_W),
      .MEM_WORDS  (MEM_WORDS),
      .WAIT_STATES(WAIT_STATES)
   ) u_ram (
      .clk  (clk),
      .rst_x(rst_x),
      .wb   (u_wb.slave)
   );

endmodule

`default_nettype wire

/* logic/word_ram.sv */
// simulated word RAM behind a Wishbone classic slave port
// MEM_WORDS must be a power of two; upper word address bits are ignored
// ack comes WAIT_STATES cycles after stb rises and lasts one cycle
// read data is combinational from the addressed word
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
   parameter int ADDR_W      = 16,
   parameter int MEM_WORDS   = 1024,
   parameter int WAIT_STATES = 2
) (
   input  logic clk,
   input  logic rst_x,
   wb_if.slave  wb
);

   localparam int IDX_W = $clog2(MEM_WORDS);
   localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   logic [31:0]       mem [MEM_WORDS];
   logic [ADDR_W-3:0] word_adr;
   logic [IDX_W-1:0]  idx;
   logic [CNT_W-1:0]  wait_cnt;
   logic              req;

   assign word_adr = wb.adr;
   assign idx      = word_adr[IDX_W-1:0];         // wraps modulo MEM_WORDS
   assign req      = wb.cyc && wb.stb;

   // counts cycles of the current strobe
   always_ff @(posedge clk) begin
      if (!rst_x) begin
         wait_cnt <= '0;
      end else if (!req || wb.ack) begin
         wait_cnt <= '0;
      end else begin
         wait_cnt <= wait_cnt + CNT_W'(1);
      end
   end

   assign wb.ack = req && (wait_cnt == CNT_W'(WAIT_STATES));

   always_ff @(posedge clk) begin
      if (wb.ack && wb.we) begin
         for (int b = 0; b < 4; b++) begin
            if (wb.sel[b]) mem[idx][8*b +: 8] <= wb.dat_w[8*b +: 8];
         end
      end
   end

   assign wb.dat_r = mem[idx];

   // a held strobe gets its ack after the wait states
   a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_x)
      $rose(req) |-> ##WAIT_STATES wb.ack);

endmodule

`default_nettype wire

/* logic/lsu_sequencer.sv */
// access sequencer: takes CPU requests and runs one or two Wishbone beats
// read wins when both enables are high; requests are taken only while idle
// beat 1 goes to the next word address, wrapping at the top of the address space
// bus outputs launch one cycle after acceptance, once the lane plan is settled
`timescale 1ns/1ps
`default_nettype none

module lsu_sequencer #(
   parameter int ADDR_W = 16
) (
   input  logic                         clk,
   input  logic                         rst_x,
   input  logic                         i_rd_en,
   input  logic                         i_wr_en,
   input  logic [ADDR_W-1:0]            i_addr,
   input  logic [31:0]                  i_data,
   input  logic [2:0]                   i_ctrl,
   output logic                         o_busy,
   wb_if.master                         wb,
   output logic [lsu_pkg::OFFSET_W-1:0] o_offset,
   output lsu_pkg::access_ctrl_u        o_ctrl,
   output logic [31:0]                  o_wdata_reg,
   input  logic [3:0]                   i_sel0,
   input  logic [3:0]                   i_sel1,
   input  logic [31:0]                  i_wdata0,
   input  logic [31:0]                  i_wdata1,
   input  logic                         i_two_beats,
   output logic                         o_capture,
   output logic                         o_beat
);

   import lsu_pkg::*;

   localparam int WORD_W = ADDR_W - OFFSET_W;

   typedef enum logic [2:0] {
      S_IDLE,
      S_BEAT0,
      S_GAP,
      S_BEAT1,
      S_DONE
   } state_e;

   state_e                state_q;
   logic                  stb_q;
   logic                  is_wr_q;
   logic                  accept;
   logic [WORD_W-1:0]     word_q;       // word address of the request
   logic [OFFSET_W-1:0]   offset_q;
   access_ctrl_u          ctrl_q;
   logic [31:0]           wdata_q;
   logic [WORD_W-1:0]     adr_q;
   logic [3:0]            sel_q;
   logic [31:0]           dat_w_q;

   assign accept = (state_q == S_IDLE) && (i_rd_en || i_wr_en);

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         state_q <= S_IDLE;
         stb_q   <= 1'b0;
         is_wr_q <= 1'b0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (accept) begin
                  is_wr_q <= !i_rd_en;
                  state_q <= S_BEAT0;
               end
            end
            S_BEAT0: begin
               if (!stb_q) begin
                  stb_q <= 1'b1;                      // launch beat 0
               end else if (wb.ack) begin
                  stb_q   <= 1'b0;
                  state_q <= i_two_beats ? S_GAP : S_DONE;
               end
            end
            S_GAP: begin                              // bus idle for one cycle
               stb_q   <= 1'b1;
               state_q <= S_BEAT1;
            end
            S_BEAT1: begin
               if (wb.ack) begin
                  stb_q   <= 1'b0;
                  state_q <= S_DONE;
               end
            end
            S_DONE:  state_q <= S_IDLE;               // aligner result lands here
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // request and bus payload
   always_ff @(posedge clk) begin
      if (accept) begin
         word_q     <= i_addr[ADDR_W-1:OFFSET_W];
         offset_q   <= i_addr[OFFSET_W-1:0];
         ctrl_q.raw <= i_ctrl;
         wdata_q    <= i_data;
      end
      if (state_q == S_BEAT0 && !stb_q) begin
         adr_q   <= word_q;
         sel_q   <= i_sel0;
         dat_w_q <= i_wdata0;
      end
      if (state_q == S_GAP) begin
         adr_q   <= word_q + WORD_W'(1);              // wraps at the top
         sel_q   <= i_sel1;
         dat_w_q <= i_wdata1;
      end
   end

   assign o_busy = (state_q != S_IDLE);

   assign wb.cyc   = (state_q == S_BEAT0) || (state_q == S_BEAT1);
   assign wb.stb   = stb_q;
   assign wb.we    = stb_q && is_wr_q;
   assign wb.adr   = adr_q;
   assign wb.sel   = sel_q;
   assign wb.dat_w = dat_w_q;

   assign o_offset    = offset_q;
   assign o_ctrl      = ctrl_q;
   assign o_wdata_reg = wdata_q;

   assign o_capture = wb.ack && !is_wr_q;             // read data is on dat_r
   assign o_beat    = (state_q == S_BEAT1);

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_x)
      wb.stb |-> wb.cyc);

   // classic hold rule until the slave acks
   a_adr_hold: assert property (@(posedge clk) disable iff (!rst_x)
      (wb.stb && !wb.ack) |=> (wb.stb && $stable(wb.adr)));

endmodule

`default_nettype wire

/* logic/lsu_load_align.sv */
// load aligner: joins the read words, shifts by the byte offset, extends
// o_data updates one cycle after the last read beat and then holds
// i_offset and i_ctrl must stay stable until that update
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
   input  logic                         clk,
   input  logic                         rst_x,
   input  logic                         i_capture,
   input  logic                         i_beat,
   input  logic [31:0]                  i_dat,
   input  logic [lsu_pkg::OFFSET_W-1:0] i_offset,
   input  lsu_pkg::access_ctrl_u        i_ctrl,
   output logic [31:0]                  o_data
);

   import lsu_pkg::*;

   logic [31:0]                         word0_q;
   logic [31:0]                         word1_q;
   logic [2*WORD_BYTES*LANE_BITS-1:0]   joined;
   logic [2*WORD_BYTES*LANE_BITS-1:0]   joined_sh;
   logic [31:0]                         result;
   logic [31:0]                         data_q;
   logic                                last_beat;
   logic                                load_q;      // result update pending

   // single-beat loads finish on beat 0
   assign last_beat = i_beat || !spans_two_words(i_offset, i_ctrl.f.size);

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         load_q <= 1'b0;
      end else begin
         load_q <= i_capture && last_beat;
      end
   end

   always_ff @(posedge clk) begin
      if (i_capture && !i_beat) word0_q <= i_dat;
      if (i_capture && i_beat)  word1_q <= i_dat;
      if (load_q)               data_q  <= result;
   end

   // upper word only matters for accesses that cross a word
   assign joined    = {word1_q, word0_q};
   assign joined_sh = joined >> (LANE_BITS * i_offset);

   always_comb begin
      case (i_ctrl.f.size)
         SZ_BYTE: begin
            result = i_ctrl.f.is_unsigned ? {24'h0, joined_sh[7:0]}
                                          : {{24{joined_sh[7]}}, joined_sh[7:0]};
         end
         SZ_HALF: begin
            result = i_ctrl.f.is_unsigned ? {16'h0, joined_sh[15:0]}
                                          : {{16{joined_sh[15]}}, joined_sh[15:0]};
         end
         default: result = joined_sh[31:0];        // lw, flag has no effect
      endcase
   end

   assign o_data = data_q;

endmodule

`default_nettype wire

/* logic/lsu_lane_plan.sv */
// store lane planner, purely combinational
// beat 0 holds the lanes from the offset upward, beat 1 the bytes that spill over
// sel outputs also serve reads, where they mark the bytes of interest
`timescale 1ns/1ps
`default_nettype none

module lsu_lane_plan (
   input  logic [lsu_pkg::OFFSET_W-1:0] i_offset,
   input  lsu_pkg::access_ctrl_u        i_ctrl,
   input  logic [31:0]                  i_wdata,
   output logic [3:0]                   o_sel0,
   output logic [3:0]                   o_sel1,
   output logic [31:0]                  o_wdata0,
   output logic [31:0]                  o_wdata1,
   output logic                         o_two_beats
);

   import lsu_pkg::*;

   logic [31:0]                         trimmed;     // store data cut to size
   logic [WORD_BYTES-1:0]               base_sel;    // lanes at offset 0
   logic [2*WORD_BYTES*LANE_BITS-1:0]   lanes;       // two words of lanes
   logic [2*WORD_BYTES-1:0]             sel_pair;

   always_comb begin
      case (i_ctrl.f.size)
         SZ_BYTE: begin
            trimmed  = {24'h0, i_wdata[7:0]};
            base_sel = 4'b0001;
         end
         SZ_HALF: begin
            trimmed  = {16'h0, i_wdata[15:0]};
            base_sel = 4'b0011;
         end
         default: begin                             // word, also funct3 size 3
            trimmed  = i_wdata;
            base_sel = 4'b1111;
         end
      endcase
   end

   // move data and mask up by the byte offset
   assign lanes    = {32'h0, trimmed} << (LANE_BITS * i_offset);
   assign sel_pair = {4'h0, base_sel} << i_offset;

   assign o_wdata0 = lanes[31:0];
   assign o_wdata1 = lanes[63:32];                  // spill into low lanes
   assign o_sel0   = sel_pair[3:0];
   assign o_sel1   = sel_pair[7:4];

   assign o_two_beats = spans_two_words(i_offset, i_ctrl.f.size);

endmodule

`default_nettype wire

/* logic/wb_if.sv */
// Wishbone classic bus, 32-bit data, word addressed
// adr carries the word address, so it is two bits narrower than the byte address
// cyc and stb are held with stable values until ack is seen
`timescale 1ns/1ps
`default_nettype none

interface wb_if #(
   parameter int ADDR_W = 16
);

   logic              cyc;
   logic              stb;
   logic              we;
   logic [ADDR_W-3:0] adr;     // word address
   logic [31:0]       dat_w;
   logic [3:0]        sel;     // byte lanes
   logic [31:0]       dat_r;
   logic              ack;

   modport master (
      output cyc, stb, we, adr, dat_w, sel,
      input  dat_r, ack
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w, sel,
      output dat_r, ack
   );

endinterface

`default_nettype wire

/* logic/lsu_pkg.sv */
// shared types and lane helpers for the load/store adapter
// size encoding follows funct3[1:0]; the reserved code 3 is handled as a word
// offsets are byte offsets inside one 32-bit word
`default_nettype none

package lsu_pkg;

   localparam int WORD_BYTES = 4;                     // bytes per memory word
   localparam int LANE_BITS  = 8;                     // one byte lane
   localparam int OFFSET_W   = $clog2(WORD_BYTES);    // byte offset width

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_e;

   typedef struct packed {
      logic  is_unsigned;   // funct3[2], lbu/lhu
      size_e size;          // funct3[1:0]
   } ctrl_fields_t;

   // same three bits, raw funct3 or split fields
   typedef union packed {
      logic [2:0]   raw;
      ctrl_fields_t f;
   } access_ctrl_u;

   function automatic logic [2:0] size_bytes(size_e sz);
      case (sz)
         SZ_BYTE: return 3'd1;
         SZ_HALF: return 3'd2;
         default: return 3'd4;
      endcase
   endfunction

   // true when the access runs past the last lane of its word
   function automatic logic spans_two_words(logic [OFFSET_W-1:0] off, size_e sz);
      return ({1'b0, off} + size_bytes(sz)) > 3'(WORD_BYTES);
   endfunction

endpackage

`default_nettype wire
